//--- hw/tlb_consts.svh
/* Sizing constants for the address-translation subsystem:
   address split, TLB geometry, page-table size and clear window */
`ifndef TLB_CONSTS_SVH
`define TLB_CONSTS_SVH

// 32-bit virtual and physical addresses, 4 KB pages
`define TLB_VA_W 32
`define TLB_PAGE_OFS 12

// TLB geometry
`define TLB_DEPTH 32
`define TLB_WAYS 2

// Single-level table, VPNs at or above this fault
`define TLB_PT_ENTRIES 64

// One set cleared per cycle
`define TLB_FLUSH_CYCLES `TLB_DEPTH

`endif

//--- hw/tlb_pkg.sv
/* Shared types: page numbers, virtual address fields,
   TLB entry and page-table entry */
`include "tlb_consts.svh"

package tlb_pkg;

    // Page number width and split of the VPN into tag and set index
    localparam int PAGE_NUM_W = `TLB_VA_W - `TLB_PAGE_OFS;
    localparam int TLB_IDX_W = $clog2(`TLB_DEPTH);
    localparam int TLB_TAG_W = PAGE_NUM_W - TLB_IDX_W;

    typedef logic [PAGE_NUM_W-1:0] vpn_t;
    typedef logic [PAGE_NUM_W-1:0] ppn_t;
    typedef logic [TLB_TAG_W-1:0] tlb_tag_t;
    typedef logic [`TLB_PAGE_OFS-1:0] page_ofs_t;

    // Virtual address as page number plus offset
    typedef struct packed {
        vpn_t vpn;
        page_ofs_t ofs;
    } va_fields_t;

    // 1 + 15 + 20 bits
    typedef struct packed {
        logic valid;
        tlb_tag_t tag;
        ppn_t ppn;
    } tlb_entry_t;

    // Valid and permission bits above the physical page, 24 bits
    typedef struct packed {
        logic valid;
        logic r;
        logic w;
        logic x;
        ppn_t ppn;
    } pte_t;

endpackage

//--- hw/lut_ram.sv
/* Distributed RAM with one synchronous write port and one
   asynchronous read port, payload given as a type parameter */
module lut_ram #(
    parameter type entry_t = logic [7:0],
    parameter int DEPTH = 32
) (
    input  logic clk,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic we,
    input  entry_t wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output entry_t rdata
);

    // Storage array, maps onto LUT RAM
    entry_t mem [DEPTH];

    // Write on the clock edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Combinational read
    // New data visible the cycle after the write
    assign rdata = mem[raddr];

endmodule

//--- hw/tlb_lut_ram.sv
/* Set-associative TLB in LUT RAM: same-cycle lookup, miss tracking,
   rotating replacement and one-set-per-cycle clear */
`include "tlb_consts.svh"

module tlb_lut_ram #(
    parameter int WAYS = `TLB_WAYS,
    parameter int DEPTH = `TLB_DEPTH
) (
    input  logic clk,
    input  logic rst,
    input  logic clearing,
    input  logic abort,
    input  logic [`TLB_VA_W-1:0] va,
    input  logic rnw,
    input  logic execute,
    input  logic new_request,
    input  logic walk_write,
    input  tlb_pkg::ppn_t walk_ppn,
    input  logic walk_fault,
    output logic ready,
    output logic done,
    output logic is_fault,
    output logic [`TLB_VA_W-1:0] pa,
    output logic mmu_request,
    output logic [`TLB_VA_W-1:0] mmu_va,
    output logic mmu_rnw,
    output logic mmu_execute
);
    import tlb_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    va_fields_t va_f;
    logic [IDX_W-1:0] lookup_set;
    logic [IDX_W-1:0] clear_set;
    logic [IDX_W-1:0] write_set;
    tlb_tag_t virtual_tag;

    tlb_entry_t way_entry [WAYS];
    tlb_entry_t new_entry;
    logic [WAYS-1:0] way_we;
    logic [WAYS-1:0] tag_hit;
    logic [WAYS-1:0] repl_way;
    ppn_t hit_ppn;

    logic hit;
    logic accept;
    logic fill;
    logic fill_done;
    logic request_in_progress;

    //////////////////////////////////////////////////////////////////////
    // Address split
    assign va_f = va;
    assign lookup_set = va_f.vpn[IDX_W-1:0];
    assign virtual_tag = va_f.vpn[PAGE_NUM_W-1 -: TLB_TAG_W];

    // Own set counter, walks 0..DEPTH-1 during a clear window
    always_ff @(posedge clk) begin
        if (rst || !clearing) begin
            clear_set <= '0;
        end else begin
            clear_set <= clear_set + 1'b1;
        end
    end

    // Fill only counts while our miss is still outstanding
    assign fill = walk_write & request_in_progress;

    // Clear takes priority over a late fill
    assign write_set = clearing ? clear_set : lookup_set;
    assign way_we = clearing ? {WAYS{1'b1}} : (fill ? repl_way : '0);

    assign new_entry.valid = ~clearing;
    assign new_entry.tag = virtual_tag;
    assign new_entry.ppn = walk_ppn;

    //////////////////////////////////////////////////////////////////////
    // Way storage
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        lut_ram #(
            .entry_t(tlb_entry_t),
            .DEPTH(DEPTH)
        ) u_way_ram (
            .clk(clk),
            .waddr(write_set),
            .we(way_we[w]),
            .wdata(new_entry),
            .raddr(lookup_set),
            .rdata(way_entry[w])
        );
    end

    // One-hot victim pointer, advances after every fill
    always_ff @(posedge clk) begin
        if (rst) begin
            repl_way <= WAYS'(1);
        end else if (fill && !clearing) begin
            repl_way <= {repl_way[WAYS-2:0], repl_way[WAYS-1]};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Lookup
    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            tag_hit[i] = way_entry[i].valid && (way_entry[i].tag == virtual_tag);
        end
    end

    assign hit = |tag_hit;

    // OR of hitting ways, at most one set in a healthy TLB
    always_comb begin
        hit_ppn = '0;
        for (int i = 0; i < WAYS; i++) begin
            if (tag_hit[i]) begin
                hit_ppn |= way_entry[i].ppn;
            end
        end
    end

    assign pa = {hit_ppn, va_f.ofs};

    //////////////////////////////////////////////////////////////////////
    // Miss tracking
    assign ready = ~request_in_progress & ~clearing;
    assign accept = new_request & ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            request_in_progress <= 1'b0;
        end else if (walk_write || walk_fault || abort || clearing) begin
            request_in_progress <= 1'b0;
        end else if (accept && !hit) begin
            request_in_progress <= 1'b1;
        end
    end

    // Re-present the lookup one cycle after the fill lands
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_done <= 1'b0;
        end else begin
            fill_done <= fill & ~clearing & ~abort;
        end
    end

    assign done = hit & (accept | fill_done);
    assign is_fault = walk_fault & request_in_progress;

    // Walker side, request fields pass straight through
    assign mmu_request = request_in_progress & ~clearing;
    assign mmu_va = va;
    assign mmu_rnw = rnw;
    assign mmu_execute = execute;

endmodule

//--- hw/page_walker.sv
/* Single-level page walker with its own page-table RAM,
   permission check and fault response */
`include "tlb_consts.svh"

module page_walker (
    input  logic clk,
    input  logic rst,
    input  logic abort,
    input  logic mmu_request,
    input  logic [`TLB_VA_W-1:0] mmu_va,
    input  logic mmu_rnw,
    input  logic mmu_execute,
    input  logic pt_we,
    input  logic [$clog2(`TLB_PT_ENTRIES)-1:0] pt_index,
    input  tlb_pkg::pte_t pt_data,
    output logic write_entry,
    output tlb_pkg::ppn_t ppn,
    output logic is_fault
);
    import tlb_pkg::*;

    localparam int PT_IDX_W = $clog2(`TLB_PT_ENTRIES);

    typedef enum logic [1:0] {
        WALK_IDLE,
        WALK_READ,
        WALK_RESPOND
    } walk_state_t;

    walk_state_t state;
    va_fields_t req_va;
    vpn_t vpn_q;
    logic rnw_q;
    logic exe_q;
    logic req_q;
    logic req_rise;
    pte_t pte;
    logic out_of_range;
    logic perm_fault;
    logic fault_d;
    logic fault_q;
    ppn_t ppn_q;

    //////////////////////////////////////////////////////////////////////
    // Page table storage
    // Loaded from outside while idle, read from the latched VPN
    lut_ram #(
        .entry_t(pte_t),
        .DEPTH(`TLB_PT_ENTRIES)
    ) u_pt_ram (
        .clk(clk),
        .waddr(pt_index),
        .we(pt_we),
        .wdata(pt_data),
        .raddr(vpn_q[PT_IDX_W-1:0]),
        .rdata(pte)
    );

    //////////////////////////////////////////////////////////////////////
    // Request capture
    assign req_va = mmu_va;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= 1'b0;
        end else begin
            req_q <= mmu_request;
        end
    end

    assign req_rise = mmu_request & ~req_q;

    // Payload of the walk, loaded on an accepted request
    always_ff @(posedge clk) begin
        if (state == WALK_IDLE && req_rise) begin
            vpn_q <= req_va.vpn;
            rnw_q <= mmu_rnw;
            exe_q <= mmu_execute;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Permission check
    assign out_of_range = vpn_q >= vpn_t'(`TLB_PT_ENTRIES);

    // Each access type checks its own bit
    assign perm_fault = (exe_q & ~pte.x)
                      | (rnw_q & ~pte.r)
                      | (~rnw_q & ~pte.w);

    assign fault_d = out_of_range | ~pte.valid | perm_fault;

    // Result registered in the read state
    always_ff @(posedge clk) begin
        if (state == WALK_READ) begin
            fault_q <= fault_d;
            ppn_q <= pte.ppn;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Walk FSM
    always_ff @(posedge clk) begin
        if (rst || abort) begin
            state <= WALK_IDLE;
        end else begin
            case (state)
                WALK_IDLE: begin
                    if (req_rise) begin
                        state <= WALK_READ;
                    end
                end
                WALK_READ: state <= WALK_RESPOND;
                WALK_RESPOND: state <= WALK_IDLE;
                default: state <= WALK_IDLE;
            endcase
        end
    end

    // One-cycle response, dropped if aborted in the same cycle
    assign write_entry = (state == WALK_RESPOND) & ~fault_q & ~abort;
    assign is_fault = (state == WALK_RESPOND) & fault_q & ~abort;
    assign ppn = ppn_q;

endmodule

//--- hw/tlb_flush_seq.sv
/* Flush sequencer: stretches a flush pulse into a clear window
   of one cycle per TLB set */
`include "tlb_consts.svh"

module tlb_flush_seq (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    output logic clearing
);

    localparam int CNT_W = $clog2(`TLB_FLUSH_CYCLES + 1);

    // Cycles left in the current window
    logic [CNT_W-1:0] remaining;

    // A flush during a running clear restarts the full window
    always_ff @(posedge clk) begin
        if (rst) begin
            remaining <= '0;
        end else if (flush) begin
            remaining <= CNT_W'(`TLB_FLUSH_CYCLES);
        end else if (remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

    // High for exactly the window length after the pulse
    assign clearing = (remaining != '0);

endmodule

//--- hw/tlb_subsystem.sv
/* Top level of the translation subsystem: TLB, page walker
   and flush sequencer */
`include "tlb_consts.svh"

module tlb_subsystem (
    input  logic clk,
    input  logic rst,
    // Requester
    input  logic [`TLB_VA_W-1:0] va,
    input  logic rnw,
    input  logic execute,
    input  logic new_request,
    output logic ready,
    output logic done,
    output logic is_fault,
    output logic [`TLB_VA_W-1:0] pa,
    // Page-table load
    input  logic pt_we,
    input  logic [$clog2(`TLB_PT_ENTRIES)-1:0] pt_index,
    input  tlb_pkg::pte_t pt_data,
    // Maintenance
    input  logic flush,
    input  logic abort
);
    import tlb_pkg::*;

    // TLB to walker
    logic mmu_request;
    logic [`TLB_VA_W-1:0] mmu_va;
    logic mmu_rnw;
    logic mmu_execute;
    logic walk_write;
    logic walk_fault;
    ppn_t walk_ppn;

    logic clearing;

    //////////////////////////////////////////////////////////////////////
    tlb_lut_ram #(
        .WAYS(`TLB_WAYS),
        .DEPTH(`TLB_DEPTH)
    ) u_tlb (
        .clk(clk),
        .rst(rst),
        .clearing(clearing),
        .abort(abort),
        .va(va),
        .rnw(rnw),
        .execute(execute),
        .new_request(new_request),
        .walk_write(walk_write),
        .walk_ppn(walk_ppn),
        .walk_fault(walk_fault),
        .ready(ready),
        .done(done),
        .is_fault(is_fault),
        .pa(pa),
        .mmu_request(mmu_request),
        .mmu_va(mmu_va),
        .mmu_rnw(mmu_rnw),
        .mmu_execute(mmu_execute)
    );

    page_walker u_walker (
        .clk(clk),
        .rst(rst),
        .abort(abort),
        .mmu_request(mmu_request),
        .mmu_va(mmu_va),
        .mmu_rnw(mmu_rnw),
        .mmu_execute(mmu_execute),
        .pt_we(pt_we),
        .pt_index(pt_index),
        .pt_data(pt_data),
        .write_entry(walk_write),
        .ppn(walk_ppn),
        .is_fault(walk_fault)
    );

    tlb_flush_seq u_flush (
        .clk(clk),
        .rst(rst),
        .flush(flush),
        .clearing(clearing)
    );

endmodule

//--- dv/tlb_checker.sv
/* Concurrent assertions on the TLB hit and strobe rules,
   bound into every tlb_lut_ram instance */
module tlb_checker #(
    parameter int WAYS = 2
) (
    input logic clk,
    input logic rst,
    input logic done,
    input logic is_fault,
    input logic clearing,
    input logic mmu_request,
    input logic [WAYS-1:0] tag_hit
);
    timeunit 1ns;
    timeprecision 1ps;

    // A completed lookup matches in exactly one way
    done_one_hot: assert property (@(posedge clk) disable iff (rst)
        done |-> $onehot(tag_hit))
        else $error("done raised without exactly one hitting way");

    // Completion and fault are exclusive
    done_fault_excl: assert property (@(posedge clk) disable iff (rst)
        !(done && is_fault))
        else $error("done and is_fault raised in the same cycle");

    // No walk is requested during a clear window
    no_walk_in_clear: assert property (@(posedge clk) disable iff (rst)
        clearing |-> !mmu_request)
        else $error("mmu_request raised while the TLB is clearing");

endmodule

bind tlb_lut_ram tlb_checker #(
    .WAYS(WAYS)
) u_checker (
    .clk(clk),
    .rst(rst),
    .done(done),
    .is_fault(is_fault),
    .clearing(clearing),
    .mmu_request(mmu_request),
    .tag_hit(tag_hit)
);

//--- dv/tlb_tb.sv
/* Testbench for the translation subsystem: page-table load, directed and
   random requests, reference model, compare process and timeout */
`include "tlb_consts.svh"

module tlb_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import tlb_pkg::*;

    localparam int PT_IDX_W = $clog2(`TLB_PT_ENTRIES);
    localparam int RANDOM_REQUESTS = 300;
    // Directed 25 plus the random mix
    localparam int NUM_REQUESTS = 25 + RANDOM_REQUESTS;
    localparam int TIMEOUT_CYCLES = NUM_REQUESTS * 8 + 200;

    // Expected result of one request
    typedef struct packed {
        logic fault;
        logic hit;
        logic [`TLB_VA_W-1:0] pa;
    } outcome_t;

    logic clk = 1'b0;
    logic rst;
    logic [`TLB_VA_W-1:0] va;
    logic rnw;
    logic execute;
    logic new_request;
    logic ready;
    logic done;
    logic is_fault;
    logic [`TLB_VA_W-1:0] pa;
    logic pt_we;
    logic [PT_IDX_W-1:0] pt_index;
    pte_t pt_data;
    logic flush;
    logic abort;

    // Shadow page table and shadow TLB contents
    pte_t pt_shadow [`TLB_PT_ENTRIES];
    logic cache_valid [`TLB_DEPTH][`TLB_WAYS];
    vpn_t cache_vpn [`TLB_DEPTH][`TLB_WAYS];
    ppn_t cache_ppn [`TLB_DEPTH][`TLB_WAYS];
    int repl_next = 0;

    // Request bookkeeping, one writer each
    logic exp_fault;
    logic [`TLB_VA_W-1:0] exp_pa;
    int exp_latency;
    int issue_stamp;
    int req_seq = 0;
    int resp_count = 0;
    int neg_count = 0;
    int cycle_count = 0;
    logic [31:0] lfsr_state;

    always #4 clk = ~clk;

    tlb_subsystem u_dut (
        .clk(clk),
        .rst(rst),
        .va(va),
        .rnw(rnw),
        .execute(execute),
        .new_request(new_request),
        .ready(ready),
        .done(done),
        .is_fault(is_fault),
        .pa(pa),
        .pt_we(pt_we),
        .pt_index(pt_index),
        .pt_data(pt_data),
        .flush(flush),
        .abort(abort)
    );

    //////////////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_pa(input logic [`TLB_VA_W-1:0] got,
                            input logic [`TLB_VA_W-1:0] expected, input string what);
        if (got !== expected) begin
            report_failure($sformatf("ERROR at %0t ns: %s is %h, expected %h",
                                     $time, what, got, expected));
        end
    endtask

    task automatic check_flag(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            report_failure($sformatf("ERROR at %0t ns: %s is %b, expected %b",
                                     $time, what, got, expected));
        end
    endtask

    task automatic check_cycles(input int got, input int expected, input string what);
        if (got != expected) begin
            report_failure($sformatf("ERROR at %0t ns: %s is %0d cycles, expected %0d",
                                     $time, what, got, expected));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Random source
    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic pte_t make_pte(input logic v, input logic r, input logic w,
                                      input logic x);
        pte_t p;
        p.valid = v;
        p.r = r;
        p.w = w;
        p.x = x;
        p.ppn = ppn_t'(take_bits(20));
        return p;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    // Hit returns the cached ppn, otherwise a walk with permission check
    function automatic outcome_t predict(input vpn_t vpn, input page_ofs_t ofs,
                                         input logic rd, input logic exe);
        outcome_t o;
        pte_t p;
        int set_idx;
        o = '0;
        set_idx = int'(vpn) % `TLB_DEPTH;
        for (int w = 0; w < `TLB_WAYS; w++) begin
            if (cache_valid[set_idx][w] && cache_vpn[set_idx][w] == vpn) begin
                o.hit = 1'b1;
                o.pa = {cache_ppn[set_idx][w], ofs};
            end
        end
        if (!o.hit) begin
            if (int'(vpn) >= `TLB_PT_ENTRIES) begin
                o.fault = 1'b1;
            end else begin
                p = pt_shadow[int'(vpn)];
                o.fault = !p.valid || (exe && !p.x) || (rd && !p.r) || (!rd && !p.w);
                o.pa = {p.ppn, ofs};
            end
        end
        return o;
    endfunction

    // Fills rotate over the ways across all sets
    task automatic record_fill(input vpn_t vpn, input ppn_t ppn);
        int set_idx;
        set_idx = int'(vpn) % `TLB_DEPTH;
        cache_valid[set_idx][repl_next] = 1'b1;
        cache_vpn[set_idx][repl_next] = vpn;
        cache_ppn[set_idx][repl_next] = ppn;
        repl_next = (repl_next + 1) % `TLB_WAYS;
    endtask

    task automatic clear_shadow_tlb();
        for (int s = 0; s < `TLB_DEPTH; s++) begin
            for (int w = 0; w < `TLB_WAYS; w++) begin
                cache_valid[s][w] = 1'b0;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare process
    // Latency counted in whole cycles from the issuing edge
    always @(negedge clk) begin
        neg_count = neg_count + 1;
        if (!rst && (done || is_fault)) begin
            if (resp_count == req_seq) begin
                report_failure($sformatf("ERROR at %0t ns: response with no open request",
                                         $time));
            end else begin
                check_flag(is_fault, exp_fault, "is_fault");
                check_flag(done, ~exp_fault, "done");
                if (!exp_fault) begin
                    check_pa(pa, exp_pa, "pa");
                end
                if (exp_latency >= 0) begin
                    check_cycles(neg_count - issue_stamp - 1, exp_latency, "latency");
                end
                resp_count = resp_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout: run did not finish within %0d cycles",
                                     TIMEOUT_CYCLES));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    task automatic write_pte(input int idx, input pte_t p);
        @(posedge clk);
        pt_we <= 1'b1;
        pt_index <= PT_IDX_W'(idx);
        pt_data <= p;
        pt_shadow[idx] = p;
    endtask

    task automatic load_page_table();
        pte_t p;
        for (int i = 0; i < `TLB_PT_ENTRIES; i++) begin
            // Three in four entries valid
            p.valid = (take_bits(2) != 32'd0);
            p.r = (take_bits(1) != 32'd0);
            p.w = (take_bits(1) != 32'd0);
            p.x = (take_bits(1) != 32'd0);
            p.ppn = ppn_t'(take_bits(20));
            write_pte(i, p);
        end
        // Directed pages
        write_pte(20, make_pte(1'b1, 1'b1, 1'b1, 1'b1));
        write_pte(52, make_pte(1'b1, 1'b1, 1'b1, 1'b1));
        write_pte(40, make_pte(1'b1, 1'b1, 1'b0, 1'b0));
        write_pte(41, make_pte(1'b0, 1'b1, 1'b1, 1'b1));
        write_pte(42, make_pte(1'b1, 1'b1, 1'b0, 1'b0));
        @(posedge clk);
        pt_we <= 1'b0;
    endtask

    // Issue one request and wait until the compare process has seen it
    task automatic run_request(input vpn_t vpn, input page_ofs_t ofs, input logic rd,
                               input logic exe, input logic check_lat);
        outcome_t exp;
        exp = predict(vpn, ofs, rd, exe);
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        va <= {vpn, ofs};
        rnw <= rd;
        execute <= exe;
        new_request <= 1'b1;
        exp_fault = exp.fault;
        exp_pa = exp.pa;
        if (!check_lat) begin
            exp_latency = -1;
        end else if (exp.fault) begin
            exp_latency = 3;
        end else if (exp.hit) begin
            exp_latency = 0;
        end else begin
            exp_latency = 4;
        end
        issue_stamp = neg_count;
        req_seq = req_seq + 1;
        @(posedge clk);
        new_request <= 1'b0;
        while (resp_count != req_seq) begin
            @(posedge clk);
        end
        if (!exp.fault && !exp.hit) begin
            record_fill(vpn, exp.pa[`TLB_VA_W-1:`TLB_PAGE_OFS]);
        end
    endtask

    // Page 40 is read-only, so the write and execute hits skip the check
    task automatic cold_miss_then_hits();
        run_request(vpn_t'(40), page_ofs_t'(take_bits(12)), 1'b1, 1'b0, 1'b1);
        run_request(vpn_t'(40), page_ofs_t'(take_bits(12)), 1'b1, 1'b0, 1'b1);
        run_request(vpn_t'(40), page_ofs_t'(take_bits(12)), 1'b0, 1'b0, 1'b1);
        run_request(vpn_t'(40), page_ofs_t'(take_bits(12)), 1'b1, 1'b1, 1'b1);
    endtask

    task automatic fault_cases();
        // Invalid PTE, then past the table
        repeat (2) run_request(vpn_t'(41), page_ofs_t'(take_bits(12)), 1'b1, 1'b0, 1'b1);
        repeat (2) run_request(vpn_t'(100), page_ofs_t'(take_bits(12)), 1'b1, 1'b0, 1'b1);
        // Write and execute on a read-only page
        repeat (2) run_request(vpn_t'(42), page_ofs_t'(take_bits(12)), 1'b0, 1'b0, 1'b1);
        run_request(vpn_t'(42), page_ofs_t'(take_bits(12)), 1'b1, 1'b1, 1'b1);
        // Still uncached, so a permitted read walks
        run_request(vpn_t'(42), page_ofs_t'(take_bits(12)), 1'b1, 1'b0, 1'b1);
    endtask

    // Set 20 holds only two in-range pages, page 84 lies past the table
    task automatic replacement_set();
        vpn_t pages [3];
        pages[0] = vpn_t'(20);
        pages[1] = vpn_t'(52);
        pages[2] = vpn_t'(84);
        for (int i = 0; i < 12; i++) begin
            run_request(pages[i % 3], page_ofs_t'(take_bits(12)), 1'b1, 1'b0, 1'b0);
        end
    endtask

    task automatic flush_then_miss();
        int low_cycles;
        low_cycles = 0;
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        while (!ready) begin
            low_cycles++;
            @(negedge clk);
        end
        check_cycles(low_cycles, `TLB_FLUSH_CYCLES, "ready low after flush");
        clear_shadow_tlb();
        run_request(vpn_t'(40), page_ofs_t'(take_bits(12)), 1'b1, 1'b0, 1'b1);
    endtask

    task automatic random_mix();
        vpn_t page;
        page_ofs_t ofs;
        logic rd;
        logic exe;
        for (int n = 0; n < RANDOM_REQUESTS; n++) begin
            // 16 pages on 8 sets, two pages compete for each set
            page = vpn_t'(take_bits(4)) << 2;
            ofs = page_ofs_t'(take_bits(12));
            rd = (take_bits(1) != 32'd0);
            exe = (take_bits(1) != 32'd0);
            run_request(page, ofs, rd, exe, 1'b1);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        rst = 1'b1;
        va = '0;
        rnw = 1'b0;
        execute = 1'b0;
        new_request = 1'b0;
        pt_we = 1'b0;
        pt_index = '0;
        pt_data = '0;
        flush = 1'b0;
        abort = 1'b0;
        lfsr_state = 32'h4d88;
        clear_shadow_tlb();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag(ready, 1'b1, "ready after reset");
        check_flag(done, 1'b0, "done after reset");
        check_flag(is_fault, 1'b0, "is_fault after reset");

        load_page_table();
        cold_miss_then_hits();
        fault_cases();
        replacement_set();
        flush_then_miss();
        random_mix();

        if (resp_count == NUM_REQUESTS) begin
            $display("Test passed");
            $finish;
        end else begin
            report_failure($sformatf("Only %0d of %0d responses were checked",
                                     resp_count, NUM_REQUESTS));
        end
    end

endmodule

//--- project.f
+incdir+hw
hw/tlb_pkg.sv
hw/lut_ram.sv
hw/tlb_lut_ram.sv
hw/page_walker.sv
hw/tlb_flush_seq.sv
hw/tlb_subsystem.sv
dv/tlb_checker.sv
dv/tlb_tb.sv

//--- Makefile
# Verilator build and run of the translation subsystem testbench

VERILATOR ?= verilator
TOP       ?= tlb_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard hw/*.sv hw/*.svh dv/*.sv)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test passed"

clean:
	rm -rf $(OBJ_DIR)
